// ==== src/bru_pkg.sv ====
`default_nettype none

package bru_pkg;

  // ==========================================================================
  // Widths and sizes
  // ==========================================================================
  localparam int EPOCH_W  = 2;
  localparam int ROB_W    = 5;
  localparam int PHYS_W   = 6;
  localparam int IQ_DEPTH = 4;

  // Queue pointer and occupancy counter widths
  localparam int IQ_PTR_W = $clog2(IQ_DEPTH);
  localparam int IQ_CNT_W = $clog2(IQ_DEPTH + 1);

  // ==========================================================================
  // Micro-op encodings
  // ==========================================================================
  typedef enum logic [2:0] {
    BR_BEQ  = 3'd0,
    BR_BNE  = 3'd1,
    BR_BLT  = 3'd2,
    BR_BGE  = 3'd3,
    BR_BLTU = 3'd4,
    BR_BGEU = 3'd5
  } branch_type_e;

  typedef enum logic [1:0] {
    UOP_BRANCH = 2'd0,
    UOP_JUMP   = 2'd1,
    UOP_OTHER  = 2'd2
  } uop_class_e;

  // ==========================================================================
  // Records passed between stages
  // ==========================================================================

  // Decoded instruction as seen by the branch unit
  typedef struct packed {
    logic [31:0]  pc;
    logic [31:0]  imm;
    branch_type_e branch_type;
    uop_class_e   uop_class;
    logic         uses_rs1;
    logic         uses_rd;
    logic         pred_taken;
    logic [31:0]  pred_target;
  } uop_bundle_t;

  typedef struct packed {
    uop_bundle_t       bundle;
    logic [EPOCH_W-1:0] epoch;
    logic [ROB_W-1:0]  rob_idx;
    logic [PHYS_W-1:0] prd_new;
  } rs_uop_t;

  // Operands travel with the micro-op, no register file read here
  typedef struct packed {
    rs_uop_t     uop;
    logic [31:0] rs1_val;
    logic [31:0] rs2_val;
  } br_issue_t;

  typedef struct packed {
    logic               uses_rd;
    logic [EPOCH_W-1:0] epoch;
    logic [ROB_W-1:0]   rob_idx;
    logic [PHYS_W-1:0]  prd_new;
    logic [31:0]        data;
    logic [31:0]        pc;
  } br_wb_t;

  typedef struct packed {
    logic        act_taken;
    logic [31:0] target_pc;
    logic        mispredict;
  } br_resolve_t;

endpackage

`default_nettype wire

// ==== src/branch_issue_queue.sv ====
`timescale 1ns/1ns
`default_nettype none

module branch_issue_queue (
  input  logic               clk,
  input  logic               rst_n,

  input  logic               dispatch_valid,
  output logic               dispatch_ready,
  input  bru_pkg::br_issue_t dispatch_entry,

  output logic               issue_valid,
  input  logic               issue_ready,
  output bru_pkg::br_issue_t issue_entry,

  input  logic               redirect_valid
);

  import bru_pkg::*;

  // ==========================================================================
  // Storage and pointers
  // ==========================================================================
  br_issue_t           entries [IQ_DEPTH];
  logic [IQ_PTR_W-1:0] head_q;
  logic [IQ_PTR_W-1:0] tail_q;
  logic [IQ_CNT_W-1:0] count_q;

  logic full;
  logic empty;
  logic push;
  logic pop;

  // Wrap at IQ_DEPTH so a non power of two depth also works
  function automatic logic [IQ_PTR_W-1:0] ptr_inc(input logic [IQ_PTR_W-1:0] ptr);
    logic [IQ_PTR_W-1:0] nxt;
    nxt = (ptr == IQ_PTR_W'(IQ_DEPTH - 1)) ? '0 : ptr + 1'b1;
    return nxt;
  endfunction

  assign full  = (count_q == IQ_CNT_W'(IQ_DEPTH));
  assign empty = (count_q == '0);

  // A redirect blocks both sides for one cycle, so nothing from the wrong path
  // slips in or out while the queue is being flushed
  assign dispatch_ready = !full && !redirect_valid;
  assign issue_valid    = !empty && !redirect_valid;
  assign issue_entry    = entries[head_q];

  assign push = dispatch_valid && dispatch_ready;
  assign pop  = issue_valid && issue_ready;

  always_ff @(posedge clk) begin
    if (push) begin
      entries[tail_q] <= dispatch_entry;
    end
  end

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      head_q  <= '0;
      tail_q  <= '0;
      count_q <= '0;
    end else if (redirect_valid) begin
      // Every waiting entry is younger than the mispredicted branch
      head_q  <= '0;
      tail_q  <= '0;
      count_q <= '0;
    end else begin
      if (push) begin
        tail_q <= ptr_inc(tail_q);
      end
      if (pop) begin
        head_q <= ptr_inc(head_q);
      end
      case ({push, pop})
        2'b10:   count_q <= count_q + 1'b1;
        2'b01:   count_q <= count_q - 1'b1;
        default: count_q <= count_q;
      endcase
    end
  end

  // ==========================================================================
  // Checks
  // ==========================================================================
  a_push_pop_legal: assert property (
    @(posedge clk) disable iff (!rst_n)
    (push |-> !full) and (pop |-> !empty)
  ) else $error("issue queue push while full or pop while empty");

endmodule

`default_nettype wire

// ==== src/bru.sv ====
`timescale 1ns/1ns
`default_nettype none

module bru (
  input  logic                 clk,
  input  logic                 rst_n,

  input  logic                 req_valid,
  output logic                 req_ready,
  input  bru_pkg::br_issue_t   req_entry,

  output logic                 wb_valid,
  input  logic                 wb_ready,
  output bru_pkg::br_wb_t      wb,
  output bru_pkg::br_resolve_t resolve,

  output logic                 redirect_valid,
  output logic [31:0]          redirect_pc
);

  import bru_pkg::*;

  // ==========================================================================
  // Resolution from the incoming request
  // ==========================================================================
  uop_bundle_t bundle;
  logic [31:0] rs1_val;
  logic [31:0] rs2_val;
  logic [31:0] pc_plus4;
  logic        cond_true;
  br_resolve_t resolve_c;
  logic [31:0] redirect_pc_c;
  br_wb_t      wb_c;

  assign bundle   = req_entry.uop.bundle;
  assign rs1_val  = req_entry.rs1_val;
  assign rs2_val  = req_entry.rs2_val;
  assign pc_plus4 = bundle.pc + 32'd4;

  always_comb begin
    case (bundle.branch_type)
      BR_BEQ:  cond_true = (rs1_val == rs2_val);
      BR_BNE:  cond_true = (rs1_val != rs2_val);
      BR_BLT:  cond_true = ($signed(rs1_val) < $signed(rs2_val));
      BR_BGE:  cond_true = ($signed(rs1_val) >= $signed(rs2_val));
      BR_BLTU: cond_true = (rs1_val < rs2_val);
      BR_BGEU: cond_true = (rs1_val >= rs2_val);
      default: cond_true = 1'b0;
    endcase
  end

  always_comb begin
    resolve_c.act_taken = 1'b0;
    resolve_c.target_pc = pc_plus4;
    case (bundle.uop_class)
      UOP_BRANCH: begin
        resolve_c.act_taken = cond_true;
        resolve_c.target_pc = bundle.pc + bundle.imm;
      end
      UOP_JUMP: begin
        resolve_c.act_taken = 1'b1;
        // JALR when rs1 is a source, JAL otherwise
        if (bundle.uses_rs1) begin
          resolve_c.target_pc = (rs1_val + bundle.imm) & 32'hffff_fffe;
        end else begin
          resolve_c.target_pc = bundle.pc + bundle.imm;
        end
      end
      default: begin
        resolve_c.act_taken = 1'b0;
        resolve_c.target_pc = pc_plus4;
      end
    endcase

    // Wrong direction, or right direction but wrong target when taken
    resolve_c.mispredict = (resolve_c.act_taken != bundle.pred_taken) ||
                           (resolve_c.act_taken &&
                            (resolve_c.target_pc != bundle.pred_target));
  end

  assign redirect_pc_c = resolve_c.act_taken ? resolve_c.target_pc : pc_plus4;

  always_comb begin
    wb_c.uses_rd = bundle.uses_rd;
    wb_c.epoch   = req_entry.uop.epoch;
    wb_c.rob_idx = req_entry.uop.rob_idx;
    wb_c.prd_new = req_entry.uop.prd_new;
    wb_c.data    = pc_plus4;
    wb_c.pc      = bundle.pc;
  end

  // ==========================================================================
  // One-entry output buffer
  // ==========================================================================
  logic        out_vld_q;
  br_wb_t      wb_q;
  br_resolve_t resolve_q;
  logic [31:0] redirect_pc_q;
  logic        deq_fire;
  logic        enq_fire;

  assign deq_fire = out_vld_q && wb_ready;

  // Accept when empty or when the held result leaves this cycle
  assign req_ready = !out_vld_q || deq_fire;
  assign enq_fire  = req_valid && req_ready;

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      out_vld_q <= 1'b0;
    end else if (enq_fire) begin
      out_vld_q <= 1'b1;
    end else if (deq_fire) begin
      out_vld_q <= 1'b0;
    end
  end

  always_ff @(posedge clk) begin
    if (enq_fire) begin
      wb_q          <= wb_c;
      resolve_q     <= resolve_c;
      redirect_pc_q <= redirect_pc_c;
    end
  end

  assign wb_valid = out_vld_q;
  assign wb       = wb_q;
  assign resolve  = resolve_q;

  // Redirect pulses only in the retire cycle
  assign redirect_valid = deq_fire && resolve_q.mispredict;
  assign redirect_pc    = redirect_pc_q;

  // ==========================================================================
  // Checks
  // ==========================================================================
  a_stall_stable: assert property (
    @(posedge clk) disable iff (!rst_n)
    (wb_valid && !wb_ready) |=> (wb_valid && $stable(wb) && $stable(resolve))
  ) else $error("branch unit result changed while stalled");

endmodule

`default_nettype wire

// ==== src/branch_unit_top.sv ====
`timescale 1ns/1ns
`default_nettype none

module branch_unit_top (
  input  logic                 clk,
  input  logic                 rst_n,

  input  logic                 dispatch_valid,
  output logic                 dispatch_ready,
  input  bru_pkg::br_issue_t   dispatch_entry,

  output logic                 wb_valid,
  input  logic                 wb_ready,
  output bru_pkg::br_wb_t      wb,
  output bru_pkg::br_resolve_t resolve,

  output logic                 redirect_valid,
  output logic [31:0]          redirect_pc
);

  import bru_pkg::*;

  // Queue head to branch unit
  logic      issue_valid;
  logic      issue_ready;
  br_issue_t issue_entry;

  branch_issue_queue u_branch_issue_queue (
    .clk            (clk),
    .rst_n          (rst_n),
    .dispatch_valid (dispatch_valid),
    .dispatch_ready (dispatch_ready),
    .dispatch_entry (dispatch_entry),
    .issue_valid    (issue_valid),
    .issue_ready    (issue_ready),
    .issue_entry    (issue_entry),
    .redirect_valid (redirect_valid)
  );

  bru u_bru (
    .clk            (clk),
    .rst_n          (rst_n),
    .req_valid      (issue_valid),
    .req_ready      (issue_ready),
    .req_entry      (issue_entry),
    .wb_valid       (wb_valid),
    .wb_ready       (wb_ready),
    .wb             (wb),
    .resolve        (resolve),
    .redirect_valid (redirect_valid),
    .redirect_pc    (redirect_pc)
  );

endmodule

`default_nettype wire

// ==== bench/bru_ref.svh ====
`ifndef BRU_REF_SVH
`define BRU_REF_SVH

// Expected resolution of one entry, worked out from the RISC-V branch rules
function automatic br_resolve_t expect_resolve(
  input  br_issue_t   e,
  output logic [31:0] redir_pc,
  output logic [31:0] ret_addr
);
  uop_bundle_t b;
  logic [32:0] diff;
  logic [31:0] jalr_sum;
  logic        eq;
  logic        lt_u;
  logic        lt_s;
  br_resolve_t r;
  b    = e.uop.bundle;
  diff = {1'b0, e.rs1_val} - {1'b0, e.rs2_val};
  eq   = (diff == 33'd0);
  // Borrow out of the subtraction means rs1 is below rs2 unsigned
  lt_u = diff[32];
  // With different signs the negative operand is the smaller one
  lt_s = (e.rs1_val[31] != e.rs2_val[31]) ? e.rs1_val[31] : lt_u;
  jalr_sum    = e.rs1_val + b.imm;
  ret_addr    = b.pc + 32'd4;
  r.act_taken = 1'b0;
  r.target_pc = ret_addr;
  case (b.uop_class)
    UOP_BRANCH: begin
      case (b.branch_type)
        BR_BEQ:  r.act_taken = eq;
        BR_BNE:  r.act_taken = !eq;
        BR_BLT:  r.act_taken = lt_s;
        BR_BGE:  r.act_taken = !lt_s;
        BR_BLTU: r.act_taken = lt_u;
        BR_BGEU: r.act_taken = !lt_u;
        default: r.act_taken = 1'b0;
      endcase
      r.target_pc = b.pc + b.imm;
    end
    UOP_JUMP: begin
      r.act_taken = 1'b1;
      r.target_pc = b.uses_rs1 ? {jalr_sum[31:1], 1'b0} : b.pc + b.imm;
    end
    default: ;
  endcase
  if (r.act_taken) begin
    r.mispredict = !b.pred_taken || (b.pred_target != r.target_pc);
  end else begin
    r.mispredict = b.pred_taken;
  end
  redir_pc = r.act_taken ? r.target_pc : ret_addr;
  return r;
endfunction

`endif

// ==== bench/branch_unit_tb.sv ====
`timescale 1ns/1ns
`default_nettype none

module branch_unit_tb;

  import bru_pkg::*;

  `include "bru_ref.svh"

  localparam int TIMEOUT        = 400;
  localparam int PRED_RIGHT     = 0;
  localparam int PRED_WRONG_DIR = 1;
  localparam int PRED_WRONG_TGT = 2;
  localparam int PRED_RANDOM    = 3;

  logic        clk = 1'b0;
  logic        rst_n;
  logic        dispatch_valid;
  logic        dispatch_ready;
  br_issue_t   dispatch_entry;
  logic        wb_valid;
  logic        wb_ready;
  br_wb_t      wb;
  br_resolve_t resolve;
  logic        redirect_valid;
  logic [31:0] redirect_pc;

  logic [31:0]      lfsr_state = 32'h1464_4c41;
  logic [ROB_W-1:0] next_rob   = '0;
  int               ready_mode = 1;  // 0 held low, 1 held high, 2 random stalls
  br_issue_t        expected[$];
  int               error_count, check_count, test_count, pass_count;
  int               accepted_count, retired_count, dropped_count, redirect_count;
  logic             was_stalled = 1'b0;
  br_wb_t           held_wb;
  br_resolve_t      held_res;

  branch_unit_top u_branch_unit_top (
    .clk            (clk),
    .rst_n          (rst_n),
    .dispatch_valid (dispatch_valid),
    .dispatch_ready (dispatch_ready),
    .dispatch_entry (dispatch_entry),
    .wb_valid       (wb_valid),
    .wb_ready       (wb_ready),
    .wb             (wb),
    .resolve        (resolve),
    .redirect_valid (redirect_valid),
    .redirect_pc    (redirect_pc)
  );

  always #50 clk = ~clk;

  // ==========================================================================
  // Random numbers and stimulus helpers
  // ==========================================================================
  function automatic logic [31:0] lfsr_step(input logic [31:0] s);
    return s[0] ? ((s >> 1) ^ 32'h8020_0003) : (s >> 1);
  endfunction

  function automatic logic [31:0] rand_bits(input int count);
    logic [31:0] bits;
    bits = '0;
    for (int i = 0; i < count; i++) begin
      lfsr_state = lfsr_step(lfsr_state);
      bits = {bits[30:0], lfsr_state[0]};
    end
    return bits;
  endfunction

  task automatic build_entry(input uop_class_e cls, input branch_type_e bt, input logic jalr,
                             input int pred_mode, output br_issue_t e);
    logic [31:0] r;
    logic [31:0] tgt_pc;
    logic [31:0] ret_pc;
    br_resolve_t act;
    e = '0;
    r = rand_bits(30);
    e.uop.bundle.pc = {r[29:0], 2'b00};
    r = rand_bits(12);
    e.uop.bundle.imm         = {{19{r[11]}}, r[11:0], 1'b0};
    e.uop.bundle.branch_type = bt;
    e.uop.bundle.uop_class   = cls;
    e.uop.bundle.uses_rs1    = (cls == UOP_JUMP) ? jalr : (cls == UOP_BRANCH);
    r = rand_bits(1);
    e.uop.bundle.uses_rd = (cls == UOP_JUMP) || ((cls == UOP_OTHER) && r[0]);
    // Bias operands toward equal values and set sign bits
    e.rs1_val = rand_bits(32);
    e.rs2_val = rand_bits(32);
    r = rand_bits(2);
    case (r[1:0])
      2'd0:    e.rs2_val = e.rs1_val;
      2'd1:    e.rs1_val[31] = 1'b1;
      2'd2:    e.rs2_val[31] = 1'b1;
      default: ;
    endcase
    r = rand_bits(EPOCH_W);
    e.uop.epoch = r[EPOCH_W-1:0];
    r = rand_bits(PHYS_W);
    e.uop.prd_new = r[PHYS_W-1:0];
    e.uop.rob_idx = next_rob;
    next_rob = next_rob + ROB_W'(1);
    act = expect_resolve(e, tgt_pc, ret_pc);
    r = rand_bits(32);
    case (pred_mode)
      PRED_RIGHT: begin
        e.uop.bundle.pred_taken  = act.act_taken;
        e.uop.bundle.pred_target = act.act_taken ? act.target_pc : r;
      end
      PRED_WRONG_DIR: begin
        e.uop.bundle.pred_taken  = !act.act_taken;
        e.uop.bundle.pred_target = act.target_pc;
      end
      PRED_WRONG_TGT: begin
        e.uop.bundle.pred_taken  = 1'b1;
        e.uop.bundle.pred_target = act.target_pc ^ 32'h0000_0010;
      end
      default: begin
        e.uop.bundle.pred_taken  = r[0];
        e.uop.bundle.pred_target = r[1] ? act.target_pc : r;
      end
    endcase
  endtask

  task automatic random_entry(input int pred_mode, output br_issue_t e);
    logic [31:0] c;
    logic [31:0] t;
    logic [31:0] j;
    c = rand_bits(2);
    t = rand_bits(3);
    j = rand_bits(1);
    build_entry(uop_class_e'(2'(c % 3)), branch_type_e'(3'(t % 6)), j[0], pred_mode, e);
  endtask

  task automatic next_cycle();
    @(posedge clk);
    #1;
    case (ready_mode)
      0:       wb_ready = 1'b0;
      1:       wb_ready = 1'b1;
      default: wb_ready = (rand_bits(1) != 0);
    endcase
  endtask

  task automatic send(input br_issue_t e);
    logic accepted;
    accepted       = 1'b0;
    dispatch_entry = e;
    dispatch_valid = 1'b1;
    for (int w = 0; w < TIMEOUT && !accepted; w++) begin
      @(negedge clk);
      accepted = dispatch_ready;
      next_cycle();
    end
    dispatch_valid = 1'b0;
    assert (accepted) else begin
      $display("Dispatch was not accepted within %0d cycles", TIMEOUT);
      error_count++;
    end
  endtask

  task automatic drain();
    int w;
    dispatch_valid = 1'b0;
    w = 0;
    while (expected.size() > 0 && w < TIMEOUT) begin
      next_cycle();
      w++;
    end
    assert (expected.size() == 0) else begin
      $display("%0d entries never reached writeback", expected.size());
      error_count++;
    end
  endtask

  task automatic compare_field(input string name, input logic [31:0] got,
                               input logic [31:0] exp);
    check_count++;
    assert (got === exp) else begin
      $display("Error: %s got %h expected %h", name, got, exp);
      error_count++;
    end
  endtask

  task automatic finish_test(input string name, input int err0);
    test_count++;
    if (error_count == err0) begin
      pass_count++;
      $display("test %0d %s: ok", test_count, name);
    end else begin
      $display("test %0d %s: %0d errors", test_count, name, error_count - err0);
    end
  endtask

  // ==========================================================================
  // Scoreboard sampled at the falling edge where all outputs are settled
  // ==========================================================================
  always @(negedge clk) begin
    br_issue_t   exp_e;
    br_resolve_t exp_r;
    logic [31:0] exp_redir_pc;
    logic [31:0] exp_data;
    if (rst_n) begin
      if (was_stalled) begin
        check_count++;
        assert (wb_valid && wb === held_wb && resolve === held_res) else begin
          $display("Result dropped or changed while wb_ready was low");
          error_count++;
        end
      end
      if (redirect_valid) begin
        redirect_count++;
      end
      if (wb_valid && wb_ready) begin
        check_count++;
        retired_count++;
        assert (expected.size() > 0) else begin
          $display("Result with rob_idx %h retired with nothing outstanding", wb.rob_idx);
          error_count++;
        end
        if (expected.size() > 0) begin
          exp_e = expected.pop_front();
          exp_r = expect_resolve(exp_e, exp_redir_pc, exp_data);
          compare_field("wb.pc", wb.pc, exp_e.uop.bundle.pc);
          compare_field("wb.data", wb.data, exp_data);
          compare_field("wb.rob_idx", 32'(wb.rob_idx), 32'(exp_e.uop.rob_idx));
          compare_field("wb.prd_new", 32'(wb.prd_new), 32'(exp_e.uop.prd_new));
          compare_field("wb.epoch", 32'(wb.epoch), 32'(exp_e.uop.epoch));
          compare_field("wb.uses_rd", 32'(wb.uses_rd), 32'(exp_e.uop.bundle.uses_rd));
          compare_field("resolve.act_taken", 32'(resolve.act_taken), 32'(exp_r.act_taken));
          compare_field("resolve.target_pc", resolve.target_pc, exp_r.target_pc);
          compare_field("resolve.mispredict", 32'(resolve.mispredict),
                        32'(exp_r.mispredict));
          compare_field("redirect_valid", 32'(redirect_valid), 32'(exp_r.mispredict));
          if (exp_r.mispredict) begin
            compare_field("redirect_pc", redirect_pc, exp_redir_pc);
            // Everything still queued is younger and gets flushed
            dropped_count += expected.size();
            expected.delete();
          end
        end
      end else begin
        check_count++;
        assert (!redirect_valid) else begin
          $display("Redirect pulsed with no result retiring");
          error_count++;
        end
      end
      if (dispatch_valid && dispatch_ready) begin
        expected.push_back(dispatch_entry);
        accepted_count++;
      end
      was_stalled = wb_valid && !wb_ready;
      held_wb     = wb;
      held_res    = resolve;
    end
  end

  // ==========================================================================
  // Test sequence
  // ==========================================================================
  initial begin
    br_issue_t   e;
    br_resolve_t res;
    logic [31:0] pc_tmp;
    logic [31:0] data_tmp;
    logic        filled;
    int          err0, acc0, ret0, drop0, redir0, expect_redir;
    rst_n          = 1'b0;
    dispatch_valid = 1'b0;
    dispatch_entry = '0;
    wb_ready       = 1'b0;
    repeat (2) @(posedge clk);
    #1 rst_n = 1'b1;
    @(negedge clk);
    assert (!wb_valid && !redirect_valid && dispatch_ready &&
            !u_branch_unit_top.u_branch_issue_queue.issue_valid) else begin
      $display("Handshake outputs are not idle after reset");
      error_count++;
    end
    next_cycle();

    err0 = error_count;
    for (int t = 0; t < 6; t++) begin
      for (int k = 0; k < 8; k++) begin
        build_entry(UOP_BRANCH, branch_type_e'(3'(t)), 1'b0, PRED_RIGHT, e);
        send(e);
      end
    end
    drain();
    finish_test("conditional branches", err0);

    err0 = error_count;
    for (int k = 0; k < 12; k++) begin
      build_entry(UOP_JUMP, BR_BEQ, k[0], PRED_RIGHT, e);
      send(e);
    end
    drain();
    finish_test("jal and jalr", err0);

    // One entry at a time so each redirect stands alone
    err0         = error_count;
    redir0       = redirect_count;
    expect_redir = 0;
    for (int k = 0; k < 12; k++) begin
      random_entry(k % 3, e);
      res = expect_resolve(e, pc_tmp, data_tmp);
      expect_redir += res.mispredict ? 1 : 0;
      send(e);
      drain();
    end
    compare_field("redirect_valid pulses", redirect_count - redir0, expect_redir);
    finish_test("prediction check", err0);

    // Mispredict held in the output buffer while younger entries queue up
    err0       = error_count;
    ret0       = retired_count;
    drop0      = dropped_count;
    ready_mode = 0;
    next_cycle();
    build_entry(UOP_BRANCH, BR_BNE, 1'b0, PRED_WRONG_DIR, e);
    send(e);
    for (int k = 0; k < 3; k++) begin
      build_entry(UOP_JUMP, BR_BEQ, 1'b0, PRED_RIGHT, e);
      send(e);
    end
    ready_mode = 1;
    drain();
    compare_field("flushed entries", dropped_count - drop0, 3);
    for (int k = 0; k < 4; k++) begin
      random_entry(PRED_RIGHT, e);
      send(e);
    end
    drain();
    compare_field("retired entries", retired_count - ret0, 5);
    finish_test("redirect flush", err0);

    // Fill the queue and the output buffer with wb_ready held low
    err0       = error_count;
    acc0       = accepted_count;
    ret0       = retired_count;
    ready_mode = 0;
    next_cycle();
    filled = 1'b0;
    random_entry(PRED_RIGHT, e);
    dispatch_entry = e;
    dispatch_valid = 1'b1;
    for (int w = 0; w < TIMEOUT && !filled; w++) begin
      @(negedge clk);
      filled = !dispatch_ready;
      next_cycle();
      if (!filled) begin
        random_entry(PRED_RIGHT, e);
        dispatch_entry = e;
      end
    end
    dispatch_valid = 1'b0;
    assert (filled) else begin
      $display("dispatch_ready never fell with wb_ready held low");
      error_count++;
    end
    compare_field("entries accepted until full", accepted_count - acc0, IQ_DEPTH + 1);
    ready_mode = 2;
    for (int k = 0; k < 20; k++) begin
      random_entry(PRED_RIGHT, e);
      send(e);
    end
    drain();
    compare_field("retired entries", retired_count - ret0, accepted_count - acc0);
    finish_test("back-pressure", err0);

    err0  = error_count;
    acc0  = accepted_count;
    ret0  = retired_count;
    drop0 = dropped_count;
    for (int k = 0; k < 24; k++) begin
      random_entry(PRED_RANDOM, e);
      send(e);
    end
    drain();
    compare_field("retired plus flushed", (retired_count - ret0) + (dropped_count - drop0),
                  accepted_count - acc0);
    finish_test("random order", err0);

    $display("tests %0d, passed %0d, checks %0d, errors %0d",
             test_count, pass_count, check_count, error_count);
    if (error_count == 0) begin
      $display("*** TEST PASSED ***");
    end else begin
      $display("*** TEST FAILED ***");
    end
    $finish;
  end

endmodule

`default_nettype wire

// ==== build.f ====
+incdir+bench
src/bru_pkg.sv
src/branch_issue_queue.sv
src/bru.sv
src/branch_unit_top.sv
bench/branch_unit_tb.sv

// ==== Makefile ====
SIM := obj_dir/Vbranch_unit_tb

.PHONY: run clean

run: $(SIM)
	./$(SIM) > sim.log 2>&1; cat sim.log
	@if grep -qF '*** TEST FAILED ***' sim.log; then exit 1; fi
	@grep -qF '*** TEST PASSED ***' sim.log

$(SIM): build.f $(wildcard src/*.sv bench/*.sv bench/*.svh)
	verilator --binary --timing --assert -Wno-fatal -j 0 \
	  --top-module branch_unit_tb -f build.f -o Vbranch_unit_tb

clean:
	rm -rf obj_dir sim.log
